/* hw/xt_periph_config.svh */
// XT peripheral block configuration
// Bus widths, port addresses, RAM size and PS/2 frame length

`ifndef XT_PERIPH_CONFIG_SVH
`define XT_PERIPH_CONFIG_SVH

`default_nettype none

// Chipset bus
`define XT_ADDR_W 20
`define XT_DATA_W 8

// PPI ports
`define XT_PORT_A_ADDR 8'h60
`define XT_PORT_B_ADDR 8'h61
`define XT_PORT_C_ADDR 8'h62

// 4 KB mirrored across 0x00000 to 0x1FFFF
`define XT_RAM_AW 12

// Start, 8 data, parity, stop
`define XT_PS2_FRAME_BITS 11

`default_nettype wire

`endif

/* hw/xt_bus_pkg.sv */
// XT chipset bus types
// Bus request, decoded device and read result

`include "xt_periph_config.svh"
`default_nettype none

package xt_bus_pkg;

    // Active-high view of the chipset strobes
    typedef struct packed {
        logic [`XT_ADDR_W-1:0] addr;
        logic [`XT_DATA_W-1:0] data;
        logic                  io_rd;
        logic                  io_wr;
        logic                  mem_rd;
        logic                  mem_wr;
    } bus_req_t;

    typedef enum logic [2:0] {
        dev_none,
        dev_dma,
        dev_pic,
        dev_pit,
        dev_ppi,
        dev_dma_page,
        dev_ram,
        dev_other_io
    } xt_dev_e;

    typedef struct packed {
        logic [`XT_DATA_W-1:0] data;
        logic                  valid;
    } bus_rd_t;

endpackage

`default_nettype wire

/* hw/ps2_kbd_pkg.sv */
// PS/2 keyboard types
// Receiver states and keyboard status

`include "xt_periph_config.svh"
`default_nettype none

package ps2_kbd_pkg;

    typedef enum logic [2:0] {
        ps2_idle,
        ps2_data,
        ps2_parity,
        ps2_stop,
        ps2_hold
    } ps2_state_e;

    typedef struct packed {
        logic [`XT_DATA_W-1:0] scancode;
        logic                  irq;
    } kbd_status_t;

endpackage

`default_nettype wire

/* hw/io_decode.sv */
// XT chipset address decoder
// Maps the bus request onto a single selected device

`timescale 1ns/10ps
`default_nettype none

module io_decode (
    input  xt_bus_pkg::bus_req_t req_i,
    input  logic                 address_enable_n_i,
    output xt_bus_pkg::xt_dev_e  dev_o
);
    import xt_bus_pkg::*;

    logic io_hit;
    logic ram_hit;
    logic io_strobe;

    // I/O space is 0x000 to 0x0FF here and RAM is the low 128 KB
    assign io_hit    = ~address_enable_n_i & (req_i.addr[9:8] == 2'b00);
    assign ram_hit   = ~address_enable_n_i & (req_i.addr[19:17] == 3'b000);
    assign io_strobe = req_i.io_rd | req_i.io_wr;

    always_comb begin
        if (io_hit && (io_strobe || !ram_hit)) begin
            case (req_i.addr[7:5])
                3'd0:    dev_o = dev_dma;
                3'd1:    dev_o = dev_pic;
                3'd2:    dev_o = dev_pit;
                3'd3:    dev_o = dev_ppi;
                3'd4:    dev_o = dev_dma_page;
                default: dev_o = dev_other_io;
            endcase
        end
        else if (ram_hit) begin
            dev_o = dev_ram;
        end
        else begin
            dev_o = dev_none;
        end
    end

endmodule

`default_nettype wire

/* hw/ps2_keyboard.sv */
// PS/2 keyboard receiver
// Samples frames on falling PS/2 clock edges, checks odd parity
// and holds the scancode with its interrupt until cleared

`timescale 1ns/10ps
`include "xt_periph_config.svh"
`default_nettype none

module ps2_keyboard (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     ps2_clock_i,
    input  logic                     ps2_data_i,
    input  logic                     clear_i,
    output ps2_kbd_pkg::kbd_status_t status_o
);
    import ps2_kbd_pkg::*;

    localparam int DATA_BITS = `XT_PS2_FRAME_BITS - 3;
    localparam logic [2:0] LAST_BIT = 3'(DATA_BITS - 1);

    ps2_state_e             state;
    logic [2:0]             bit_cnt;
    logic [DATA_BITS-1:0]   shift_q;
    logic                   parity_q;
    logic [`XT_DATA_W-1:0]  scancode_q;
    logic                   irq_q;

    // Two-flop synchronizers plus edge history
    logic ps2_clk_meta;
    logic ps2_clk_sync;
    logic ps2_clk_prev;
    logic ps2_dat_meta;
    logic ps2_dat_sync;
    logic ps2_fall;

    assign ps2_fall = ps2_clk_prev & ~ps2_clk_sync;

    always_ff @(posedge clock) begin
        if (reset) begin
            ps2_clk_meta <= 1'b1;
            ps2_clk_sync <= 1'b1;
            ps2_clk_prev <= 1'b1;
            ps2_dat_meta <= 1'b1;
            ps2_dat_sync <= 1'b1;
        end
        else begin
            ps2_clk_meta <= ps2_clock_i;
            ps2_clk_sync <= ps2_clk_meta;
            ps2_clk_prev <= ps2_clk_sync;
            ps2_dat_meta <= ps2_data_i;
            ps2_dat_sync <= ps2_dat_meta;
        end
    end

    // Data arrives LSB first
    always_ff @(posedge clock) begin
        if (ps2_fall) begin
            if (state == ps2_data)
                shift_q <= {ps2_dat_sync, shift_q[DATA_BITS-1:1]};
            if (state == ps2_parity)
                parity_q <= ps2_dat_sync;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= ps2_idle;
            bit_cnt    <= 3'd0;
            scancode_q <= '0;
            irq_q      <= 1'b0;
        end
        else begin
            case (state)
                ps2_idle: begin
                    // Wait for the start bit
                    if (ps2_fall && !ps2_dat_sync) begin
                        bit_cnt <= 3'd0;
                        state   <= ps2_data;
                    end
                end
                ps2_data: begin
                    if (ps2_fall) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == LAST_BIT)
                            state <= ps2_parity;
                    end
                end
                ps2_parity: begin
                    if (ps2_fall)
                        state <= ps2_stop;
                end
                ps2_stop: begin
                    if (ps2_fall) begin
                        // Good frame needs odd parity and a stop bit of 1
                        if (ps2_dat_sync && ((^shift_q) ^ parity_q)) begin
                            scancode_q <= shift_q;
                            irq_q      <= 1'b1;
                            state      <= ps2_hold;
                        end
                        else begin
                            state <= ps2_idle;
                        end
                    end
                end
                ps2_hold: begin
                    // Frames are ignored until the host clears
                    if (clear_i) begin
                        irq_q      <= 1'b0;
                        scancode_q <= '0;
                    end
                    else if (!irq_q) begin
                        state <= ps2_idle;
                    end
                end
                default: state <= ps2_idle;
            endcase
        end
    end

    assign status_o.scancode = scancode_q;
    assign status_o.irq      = irq_q;

endmodule

`default_nettype wire

/* hw/ppi_ports.sv */
// PPI-style port block
// Port A reads the scancode, port B is a read/write register,
// port C reads the input pins

`timescale 1ns/10ps
`include "xt_periph_config.svh"
`default_nettype none

module ppi_ports (
    input  logic                     clock,
    input  logic                     reset,
    input  xt_bus_pkg::bus_req_t     req_i,
    input  logic                     sel_i,
    input  ps2_kbd_pkg::kbd_status_t kbd_i,
    input  logic [7:0]               port_c_i,
    output logic [7:0]               port_b_o,
    output logic [7:0]               rdata_o
);

    localparam logic [1:0] OFS_A = 2'(`XT_PORT_A_ADDR);
    localparam logic [1:0] OFS_B = 2'(`XT_PORT_B_ADDR);
    localparam logic [1:0] OFS_C = 2'(`XT_PORT_C_ADDR);

    logic [7:0] port_b_q;

    // Only port B is writable
    always_ff @(posedge clock) begin
        if (reset) begin
            port_b_q <= 8'h00;
        end
        else if (sel_i && req_i.io_wr && (req_i.addr[1:0] == OFS_B)) begin
            port_b_q <= req_i.data;
        end
    end

    always_comb begin
        case (req_i.addr[1:0])
            OFS_A:   rdata_o = kbd_i.scancode;
            OFS_B:   rdata_o = port_b_q;
            OFS_C:   rdata_o = port_c_i;
            default: rdata_o = 8'hFF;
        endcase
    end

    assign port_b_o = port_b_q;

endmodule

`default_nettype wire

/* hw/low_ram.sv */
// Low memory RAM
// Single-port byte RAM with a registered read port

`timescale 1ns/10ps
`include "xt_periph_config.svh"
`default_nettype none

module low_ram (
    input  logic                 clock,
    input  xt_bus_pkg::bus_req_t req_i,
    input  logic                 sel_i,
    output logic [7:0]           rdata_o
);

    logic [7:0]            mem [2**`XT_RAM_AW];
    logic [`XT_RAM_AW-1:0] index;

    // Upper address bits are ignored, so the array mirrors
    assign index = req_i.addr[`XT_RAM_AW-1:0];

    always_ff @(posedge clock) begin
        if (sel_i) begin
            if (req_i.mem_wr)
                mem[index] <= req_i.data;
            rdata_o <= mem[index];
        end
    end

endmodule

`default_nettype wire

/* hw/xt_peripherals.sv */
// XT peripheral block top level
// Decoder, PPI ports, PS/2 keyboard and low RAM behind one chipset bus,
// with the prioritized read-data multiplexer

`timescale 1ns/10ps
`include "xt_periph_config.svh"
`default_nettype none

module xt_peripherals (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [`XT_ADDR_W-1:0] address_i,
    input  logic [`XT_DATA_W-1:0] data_i,
    input  logic                  io_read_n_i,
    input  logic                  io_write_n_i,
    input  logic                  memory_read_n_i,
    input  logic                  memory_write_n_i,
    input  logic                  address_enable_n_i,
    input  logic [7:0]            port_c_i,
    input  logic                  ps2_clock_i,
    input  logic                  ps2_data_i,
    output logic [`XT_DATA_W-1:0] data_bus_o,
    output logic                  data_bus_out_from_chipset_o,
    output logic                  dma_chip_select_n_o,
    output logic                  dma_page_chip_select_n_o,
    output logic [7:0]            port_b_o,
    output logic                  keyboard_irq_o,
    output logic                  ps2_busy_o
);
    import xt_bus_pkg::*;
    import ps2_kbd_pkg::*;

    bus_req_t    req;
    xt_dev_e     dev;
    kbd_status_t kbd;
    bus_rd_t     rd;
    logic        ppi_sel;
    logic        ram_sel;
    logic [7:0]  ppi_rdata;
    logic [7:0]  ram_rdata;

    assign req.addr   = address_i;
    assign req.data   = data_i;
    assign req.io_rd  = ~io_read_n_i;
    assign req.io_wr  = ~io_write_n_i;
    assign req.mem_rd = ~memory_read_n_i;
    assign req.mem_wr = ~memory_write_n_i;

    io_decode u_io_decode (
        .req_i              (req),
        .address_enable_n_i (address_enable_n_i),
        .dev_o              (dev)
    );

    assign dma_chip_select_n_o      = (dev != dev_dma);
    assign dma_page_chip_select_n_o = (dev != dev_dma_page);
    assign ppi_sel                  = (dev == dev_ppi);
    assign ram_sel                  = (dev == dev_ram);

    ps2_keyboard u_ps2_keyboard (
        .clock       (clock),
        .reset       (reset),
        .ps2_clock_i (ps2_clock_i),
        .ps2_data_i  (ps2_data_i),
        .clear_i     (port_b_o[7]),
        .status_o    (kbd)
    );

    ppi_ports u_ppi_ports (
        .clock    (clock),
        .reset    (reset),
        .req_i    (req),
        .sel_i    (ppi_sel),
        .kbd_i    (kbd),
        .port_c_i (port_c_i),
        .port_b_o (port_b_o),
        .rdata_o  (ppi_rdata)
    );

    low_ram u_low_ram (
        .clock   (clock),
        .req_i   (req),
        .sel_i   (ram_sel),
        .rdata_o (ram_rdata)
    );

    // PPI I/O read first, then RAM
    always_comb begin
        if (ppi_sel && req.io_rd) begin
            rd.data  = ppi_rdata;
            rd.valid = 1'b1;
        end
        else if (ram_sel && req.mem_rd) begin
            rd.data  = ram_rdata;
            rd.valid = 1'b1;
        end
        else begin
            rd.data  = '0;
            rd.valid = 1'b0;
        end
    end

    assign data_bus_o                  = rd.data;
    assign data_bus_out_from_chipset_o = rd.valid;

    // Busy also while the host holds the keyboard off via port B bit 6
    assign keyboard_irq_o = kbd.irq;
    assign ps2_busy_o     = kbd.irq | ~port_b_o[6];

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
// Testbench clock source
// Free-running 10 ns clock

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clock_o
);

    initial begin
        clock_o = 1'b0;
        forever #5 clock_o = ~clock_o;
    end

endmodule

`default_nettype wire

/* dv/xt_peripherals_properties.sv */
// XT peripheral block bus and keyboard rules
// Concurrent checks bound into the top level

`timescale 1ns/10ps
`include "xt_periph_config.svh"
`default_nettype none

module xt_peripherals_properties (
    input logic                  clock,
    input logic                  reset,
    input logic [`XT_DATA_W-1:0] data_bus_i,
    input logic                  data_valid_i,
    input logic                  dma_cs_n_i,
    input logic                  dma_page_cs_n_i,
    input logic                  irq_i,
    input logic                  busy_i
);

    irq_implies_busy: assert property (@(posedge clock) disable iff (reset) irq_i |-> busy_i)
        else $error("keyboard irq is high while ps2 busy is low");

    // Idle bus carries zero data
    idle_bus_zero: assert property (@(posedge clock) disable iff (reset)
        !data_valid_i |-> (data_bus_i == '0))
        else $error("data bus is nonzero while the chipset is not driving it");

    dma_selects_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(!dma_cs_n_i && !dma_page_cs_n_i))
        else $error("DMA and DMA page selects are low together");

endmodule

bind xt_peripherals xt_peripherals_properties u_properties (
    .clock           (clock),
    .reset           (reset),
    .data_bus_i      (data_bus_o),
    .data_valid_i    (data_bus_out_from_chipset_o),
    .dma_cs_n_i      (dma_chip_select_n_o),
    .dma_page_cs_n_i (dma_page_chip_select_n_o),
    .irq_i           (keyboard_irq_o),
    .busy_i          (ps2_busy_o)
);

`default_nettype wire

/* dv/xt_peripherals_tb.sv */
// XT peripheral block testbench
// Table-driven bus cycles and PS/2 frames against the top level

`timescale 1ns/10ps
`include "xt_periph_config.svh"
`default_nettype none

module xt_peripherals_tb;

    typedef enum logic [2:0] {
        op_io_wr,
        op_io_rd,
        op_mem_wr,
        op_mem_rd,
        op_ps2,
        op_idle
    } op_e;

    typedef struct packed {
        op_e                   op;
        logic                  aen_n;
        logic [`XT_ADDR_W-1:0] addr;
        logic [7:0]            data;
        logic                  bad_par;
        logic [7:0]            exp_data;
        logic                  exp_flag;
        logic                  exp_irq;
        logic                  exp_dma_n;
        logic                  exp_page_n;
    } row_t;

    localparam int NUM_ROWS = 32;
    localparam int CYCLE_LIMIT = NUM_ROWS * 400 + 200;
    localparam logic [7:0] PORT_C_VALUE = 8'hC3;

    // op, aen_n, addr, data, bad parity, exp data, flag, irq, dma_n, page_n
    // Memory rows take random addresses and data
    localparam row_t ROWS [NUM_ROWS] = '{
        '{op_idle,   1'b0, 20'h00000, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
        '{op_io_rd,  1'b0, 20'h00000, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1},
        '{op_io_rd,  1'b0, 20'h0001F, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1},
        '{op_io_rd,  1'b0, 20'h00080, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0},
        '{op_io_rd,  1'b0, 20'h0009F, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0},
        '{op_io_rd,  1'b1, 20'h00000, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
        '{op_io_rd,  1'b0, 20'h00100, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
        '{op_io_wr,  1'b0, 20'h00061, 8'h5A, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
        '{op_io_rd,  1'b0, 20'h00061, 8'h00, 1'b0, 8'h5A, 1'b1, 1'b0, 1'b1, 1'b1},
        '{op_io_rd,  1'b0, 20'h00062, 8'h00, 1'b0, 8'hC3, 1'b1, 1'b0, 1'b1, 1'b1},
        '{op_io_rd,  1'b0, 20'h00063, 8'h00, 1'b0, 8'hFF, 1'b1, 1'b0, 1'b1, 1'b1},
        '{op_io_rd,  1'b0, 20'h000A0, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
        '{op_mem_wr, 1'b0, 20'h00000, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
        '{op_mem_wr, 1'b0, 20'h00000, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
        '{op_mem_wr, 1'b0, 20'h00000, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
        '{op_mem_wr, 1'b0, 20'h00000, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
        '{op_mem_rd, 1'b0, 20'h00000, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0, 1'b1, 1'b1},
        '{op_mem_rd, 1'b0, 20'h00000, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0, 1'b1, 1'b1},
        '{op_mem_rd, 1'b0, 20'h00000, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0, 1'b1, 1'b1},
        '{op_mem_rd, 1'b0, 20'h00000, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0, 1'b1, 1'b1},
        '{op_ps2,    1'b0, 20'h00000, 8'h1C, 1'b0, 8'h00, 1'b0, 1'b1, 1'b1, 1'b1},
        '{op_io_rd,  1'b0, 20'h00060, 8'h00, 1'b0, 8'h1C, 1'b1, 1'b1, 1'b1, 1'b1},
        '{op_ps2,    1'b0, 20'h00000, 8'h32, 1'b0, 8'h00, 1'b0, 1'b1, 1'b1, 1'b1},
        '{op_io_rd,  1'b0, 20'h00060, 8'h00, 1'b0, 8'h1C, 1'b1, 1'b1, 1'b1, 1'b1},
        '{op_io_wr,  1'b0, 20'h00061, 8'hC0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
        '{op_io_rd,  1'b0, 20'h00060, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0, 1'b1, 1'b1},
        '{op_io_wr,  1'b0, 20'h00061, 8'h40, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
        '{op_ps2,    1'b0, 20'h00000, 8'h1C, 1'b1, 8'h00, 1'b0, 1'b0, 1'b1, 1'b1},
        '{op_io_rd,  1'b0, 20'h00060, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0, 1'b1, 1'b1},
        '{op_ps2,    1'b0, 20'h00000, 8'h2A, 1'b0, 8'h00, 1'b0, 1'b1, 1'b1, 1'b1},
        '{op_io_rd,  1'b0, 20'h00060, 8'h00, 1'b0, 8'h2A, 1'b1, 1'b1, 1'b1, 1'b1},
        '{op_idle,   1'b0, 20'h00000, 8'h00, 1'b0, 8'h00, 1'b0, 1'b1, 1'b1, 1'b1}
    };

    logic                  clock;
    logic                  reset;
    logic [`XT_ADDR_W-1:0] address;
    logic [7:0]            data_in;
    logic                  io_read_n;
    logic                  io_write_n;
    logic                  mem_read_n;
    logic                  mem_write_n;
    logic                  aen_n;
    logic [7:0]            port_c;
    logic                  ps2_clk;
    logic                  ps2_data;
    logic [7:0]            data_bus;
    logic                  data_flag;
    logic                  dma_cs_n;
    logic                  page_cs_n;
    logic [7:0]            port_b;
    logic                  kbd_irq;
    logic                  ps2_busy;

    // Reference state kept by the testbench
    logic [7:0]            ram_model [2**`XT_RAM_AW];
    logic [`XT_ADDR_W-1:0] written_addrs [$];
    logic [7:0]            port_b_model;
    int                    cycles;

    tb_clock_gen u_clock_gen (
        .clock_o (clock)
    );

    xt_peripherals uut (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_i                      (data_in),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .memory_read_n_i             (mem_read_n),
        .memory_write_n_i            (mem_write_n),
        .address_enable_n_i          (aen_n),
        .port_c_i                    (port_c),
        .ps2_clock_i                 (ps2_clk),
        .ps2_data_i                  (ps2_data),
        .data_bus_o                  (data_bus),
        .data_bus_out_from_chipset_o (data_flag),
        .dma_chip_select_n_o         (dma_cs_n),
        .dma_page_chip_select_n_o    (page_cs_n),
        .port_b_o                    (port_b),
        .keyboard_irq_o              (kbd_irq),
        .ps2_busy_o                  (ps2_busy)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        assert (actual === expected)
        else fail_run($sformatf("error: %s = 0x%h, expected 0x%h", name, actual, expected));
    endtask

    // Start 0, data LSB first, odd parity, stop 1
    task automatic send_frame(input logic [7:0] code, input logic bad_par);
        logic [`XT_PS2_FRAME_BITS-1:0] frame;
        frame = {1'b1, ~(^code) ^ bad_par, code, 1'b0};
        @(posedge clock);
        for (int i = 0; i < `XT_PS2_FRAME_BITS; i++) begin
            ps2_data <= frame[i];
            repeat (8) @(posedge clock);
            ps2_clk <= 1'b0;
            repeat (8) @(posedge clock);
            ps2_clk <= 1'b1;
        end
        ps2_data <= 1'b1;
        repeat (8) @(posedge clock);
        @(negedge clock);
    endtask

    // Strobe held for three cycles, sampled in the last one
    task automatic bus_cycle(input row_t r, input logic [`XT_ADDR_W-1:0] addr,
                             input logic [7:0] data);
        @(posedge clock);
        address     <= addr;
        data_in     <= data;
        aen_n       <= r.aen_n;
        io_read_n   <= (r.op != op_io_rd);
        io_write_n  <= (r.op != op_io_wr);
        mem_read_n  <= (r.op != op_mem_rd);
        mem_write_n <= (r.op != op_mem_wr);
        repeat (2) @(posedge clock);
        @(negedge clock);
    endtask

    task automatic release_bus();
        @(posedge clock);
        address     <= '0;
        data_in     <= 8'h00;
        aen_n       <= 1'b0;
        io_read_n   <= 1'b1;
        io_write_n  <= 1'b1;
        mem_read_n  <= 1'b1;
        mem_write_n <= 1'b1;
    endtask

    task automatic check_row(input row_t r, input logic [7:0] exp_data);
        check_value("data_bus_o", data_bus, exp_data);
        check_value("data_bus_out_from_chipset_o", {7'b0, data_flag}, {7'b0, r.exp_flag});
        check_value("keyboard_irq_o", {7'b0, kbd_irq}, {7'b0, r.exp_irq});
        check_value("dma_chip_select_n_o", {7'b0, dma_cs_n}, {7'b0, r.exp_dma_n});
        check_value("dma_page_chip_select_n_o", {7'b0, page_cs_n}, {7'b0, r.exp_page_n});
        check_value("port_b_o", port_b, port_b_model);
        check_value("ps2_busy_o", {7'b0, ps2_busy},
                    {7'b0, r.exp_irq | ~port_b_model[6]});
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            fail_run($sformatf("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT));
    end

    initial begin : stimulus
        row_t                  r;
        logic [`XT_ADDR_W-1:0] addr;
        logic [`XT_ADDR_W-1:0] base;
        logic [7:0]            data;
        logic [7:0]            exp_data;

        void'($urandom(32'h1e2193f6));
        cycles       = 0;
        port_b_model = 8'h00;
        reset        = 1'b1;
        address      = '0;
        data_in      = 8'h00;
        io_read_n    = 1'b1;
        io_write_n   = 1'b1;
        mem_read_n   = 1'b1;
        mem_write_n  = 1'b1;
        aen_n        = 1'b0;
        port_c       = PORT_C_VALUE;
        ps2_clk      = 1'b1;
        ps2_data     = 1'b1;

        repeat (16) @(posedge clock);
        reset <= 1'b0;

        for (int n = 0; n < NUM_ROWS; n++) begin
            r        = ROWS[n];
            addr     = r.addr;
            data     = r.data;
            exp_data = r.exp_data;
            case (r.op)
                op_mem_wr: begin
                    addr = 20'($urandom) & 20'h1FFFF;
                    data = 8'($urandom);
                    ram_model[addr[`XT_RAM_AW-1:0]] = data;
                    written_addrs.push_back(addr);
                end
                op_mem_rd: begin
                    // Read back through the alias 4 KB higher
                    base     = written_addrs.pop_front();
                    addr     = (base + 20'h01000) & 20'h1FFFF;
                    exp_data = ram_model[base[`XT_RAM_AW-1:0]];
                end
                op_io_wr: begin
                    if (addr[7:0] == `XT_PORT_B_ADDR)
                        port_b_model = data;
                end
                default: begin
                end
            endcase

            if (r.op == op_ps2)
                send_frame(r.data, r.bad_par);
            else
                bus_cycle(r, addr, data);
            check_row(r, exp_data);
            release_bus();
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/xt_bus_pkg.sv
hw/ps2_kbd_pkg.sv
hw/io_decode.sv
hw/ps2_keyboard.sv
hw/ppi_ports.sv
hw/low_ram.sv
hw/xt_peripherals.sv
dv/tb_clock_gen.sv
dv/xt_peripherals_properties.sv
dv/xt_peripherals_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= xt_peripherals_tb
RTL_TOP   ?= xt_peripherals
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) hw/xt_periph_config.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
